// ==== pmp.f ====
+incdir+.
pmp_pkg.sv
pmp_napot_mask.sv
pmp_entry.sv
pmp_priority_sel.sv
pmp_unit.sv
pmp_top.sv
pmp_tb.sv

// ==== pmp_cfg.svh ====
`ifndef PMP_CFG_SVH
`define PMP_CFG_SVH

// Number of PMP entries
`define PMP_ENTRY_COUNT 16

// Each 64-bit pmpcfg word packs eight cfg bytes
`define PMP_CFG_WORDS (`PMP_ENTRY_COUNT / 8)

// Physical address width in bits
`define PMP_PADDR_WIDTH 34

// Width of an entry index on the CSR write ports
`define PMP_IDX_WIDTH $clog2(`PMP_ENTRY_COUNT)

// 1 registers the check request, 0 passes it straight through
`define PMP_INPUT_REGISTER 1

`endif

// ==== pmp_entry.sv ====
`timescale 1ns/1ps
`include "pmp_cfg.svh"

module pmp_entry (
	input  logic                        clk,
	input  logic                        reset_i,
	input  pmp_pkg::priv_lvl_e          priv_i,
	input  logic                        cfg_wr_en_i,
	input  logic [7:0]                  cfg_wr_byte_i,
	input  logic                        addr_wr_en_i,
	input  logic [`PMP_PADDR_WIDTH-3:0] addr_wr_data_i,
	input  logic                        lock_next_tor_i,
	input  logic [`PMP_PADDR_WIDTH-3:0] prev_addr_i,
	output pmp_pkg::pmp_cfg_u           cfg_o,
	output logic [`PMP_PADDR_WIDTH-3:0] addr_o,
	output logic                        lock_tor_o,
	input  pmp_pkg::pmp_req_t           req_i,
	output logic                        match_o,
	output logic                        deny_o
);

	import pmp_pkg::*;

	pmp_cfg_u                    cfg_q;
	logic [`PMP_PADDR_WIDTH-3:0] addr_q;
	logic [`PMP_PADDR_WIDTH-3:0] req_word;
	logic [`PMP_PADDR_WIDTH-3:0] cmp_mask;
	logic                        addr_wr_ok;
	logic                        tor_hit;
	logic                        point_hit;
	logic                        perm;

	// A locked entry ignores both of its writes
	assign addr_wr_ok = !cfg_q.fields.lock && !lock_next_tor_i; // Also frozen as a TOR base

	always_ff @(posedge clk) begin
		if (reset_i) begin
			cfg_q.raw <= '0;
		end else if (cfg_wr_en_i && !cfg_q.fields.lock) begin
			cfg_q.raw <= cfg_wr_byte_i;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			addr_q <= '0;
		end else if (addr_wr_en_i && addr_wr_ok) begin
			addr_q <= addr_wr_data_i;
		end
	end

	assign cfg_o      = cfg_q;
	assign addr_o     = addr_q;
	assign lock_tor_o = cfg_q.fields.lock && (cfg_q.fields.mode == MODE_TOR);

	assign req_word = req_i.paddr[`PMP_PADDR_WIDTH-1:2]; // Matching works on 4-byte words

	pmp_napot_mask u_pmp_napot_mask (
		.addr_i  (addr_q),
		.napot_i (cfg_q.fields.mode == MODE_NAPOT),
		.mask_o  (cmp_mask)
	);

	assign tor_hit   = (req_word >= prev_addr_i) && (req_word < addr_q);
	assign point_hit = ((req_word ^ addr_q) & cmp_mask) == '0;

	always_comb begin
		case (cfg_q.fields.mode)
			MODE_TOR: begin
				match_o = tor_hit;
			end
			MODE_NA4, MODE_NAPOT: begin
				match_o = point_hit;
			end
			default: begin
				match_o = 1'b0; // OFF never matches
			end
		endcase
	end

	always_comb begin
		case (req_i.access)
			ACCESS_READ: begin
				perm = cfg_q.fields.r;
			end
			ACCESS_WRITE: begin
				perm = cfg_q.fields.w;
			end
			ACCESS_EXEC: begin
				perm = cfg_q.fields.x;
			end
			default: begin
				perm = 1'b0;
			end
		endcase
	end

	// M-mode bypasses the permission bits unless the entry is locked
	assign deny_o = !perm && ((priv_i != PRIV_M) || cfg_q.fields.lock);

endmodule

// ==== pmp_napot_mask.sv ====
`timescale 1ns/1ps
`include "pmp_cfg.svh"

module pmp_napot_mask (
	input  logic [`PMP_PADDR_WIDTH-3:0] addr_i,
	input  logic                        napot_i,
	output logic [`PMP_PADDR_WIDTH-3:0] mask_o
);

	localparam int addr_w = `PMP_PADDR_WIDTH - 2;

	// Walk up from bit 0, clearing each trailing one and the first zero above them
	always_comb begin
		logic in_run;
		in_run = 1'b1;
		mask_o = '1; // NA4 compares every word address bit
		if (napot_i) begin
			for (int i = 0; i < addr_w; i++) begin
				if (in_run) begin
					mask_o[i] = 1'b0;
					in_run = addr_i[i]; // Stops after the first zero is cleared
				end
			end
		end
	end

	// An all-ones address leaves the mask empty, so the region covers all memory

endmodule

// ==== pmp_pkg.sv ====
`include "pmp_cfg.svh"

package pmp_pkg;

	typedef enum logic [1:0] {
		PRIV_U = 2'd0,
		PRIV_S = 2'd1,
		PRIV_M = 2'd3
	} priv_lvl_e;

	typedef enum logic [1:0] {
		ACCESS_READ  = 2'd0,
		ACCESS_WRITE = 2'd1,
		ACCESS_EXEC  = 2'd2
	} access_e;

	typedef enum logic [1:0] {
		MODE_OFF   = 2'd0,
		MODE_TOR   = 2'd1,
		MODE_NA4   = 2'd2,
		MODE_NAPOT = 2'd3
	} addr_mode_e;

	// Field layout of one pmpcfg byte, msb first
	typedef struct packed {
		logic       lock;
		logic [1:0] rsvd;
		addr_mode_e mode;
		logic       x;
		logic       w;
		logic       r;
	} pmp_cfg_t;

	typedef union packed {
		logic [7:0] raw; // Readback and write path
		pmp_cfg_t   fields; // Checking logic
	} pmp_cfg_u;

	typedef struct packed {
		logic [`PMP_PADDR_WIDTH-1:0] paddr;
		access_e                     access;
	} pmp_req_t;

	typedef struct packed {
		logic                      vld;
		logic [`PMP_IDX_WIDTH-1:0] idx; // The cfg port uses only the word select bits
		logic [63:0]               data;
	} pmp_csr_wr_t;

endpackage

// ==== pmp_priority_sel.sv ====
`timescale 1ns/1ps
`include "pmp_cfg.svh"

module pmp_priority_sel (
	input  logic [`PMP_ENTRY_COUNT-1:0] match_i,
	input  logic [`PMP_ENTRY_COUNT-1:0] deny_i,
	input  pmp_pkg::priv_lvl_e          priv_i,
	output logic                        fail_o
);

	import pmp_pkg::*;

	localparam int entries = `PMP_ENTRY_COUNT;

	logic [entries-1:0] first_hit;
	logic               any_hit;
	logic               hit_deny;
	logic               miss_fail;

	// Isolate the lowest set match bit
	assign first_hit = match_i & (~match_i + entries'(1));
	assign any_hit   = |match_i;

	assign hit_deny  = |(first_hit & deny_i); // Deny bit of the winning entry

	// Only M-mode may pass an access that hits no entry
	assign miss_fail = (priv_i != PRIV_M);

	always_comb begin
		if (any_hit) begin
			fail_o = hit_deny;
		end else begin
			fail_o = miss_fail;
		end
	end

endmodule

// ==== pmp_tb.sv ====
`timescale 1ns/1ps
`include "pmp_cfg.svh"

module pmp_tb;

	import pmp_pkg::*;

	localparam int entries      = `PMP_ENTRY_COUNT;
	localparam int addr_w       = `PMP_PADDR_WIDTH - 2;
	localparam int total_cycles = 8 + 24 + 36 + 283 + 47 + 27 + 411; // Sum over all tests
	localparam int margin       = 200;

	logic         clk;
	logic         reset_i;
	priv_lvl_e    priv_lvl_i;
	pmp_csr_wr_t  cfg_wr_i;
	pmp_csr_wr_t  addr_wr_i;
	logic [63:0]  cfg_rdata_o;
	logic [63:0]  addr_rdata_o;
	logic         check_vld_i;
	pmp_req_t     check_req_i;
	logic         check_fail_o;

	logic [7:0]        sh_cfg [entries];
	logic [addr_w-1:0] sh_addr [entries];
	logic              pend;
	pmp_req_t          pend_req;
	priv_lvl_e         cur_priv;
	int                errors;
	int                checks;
	int                errors_at_start;
	int                seed_val;
	logic [31:0]       spots [10];

	pmp_top u_pmp_top (
		.clk          (clk),
		.reset_i      (reset_i),
		.priv_lvl_i   (priv_lvl_i),
		.cfg_wr_i     (cfg_wr_i),
		.addr_wr_i    (addr_wr_i),
		.cfg_rdata_o  (cfg_rdata_o),
		.addr_rdata_o (addr_rdata_o),
		.check_vld_i  (check_vld_i),
		.check_req_i  (check_req_i),
		.check_fail_o (check_fail_o)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		#(total_cycles * 40 + margin * 40);
		$display("timeout: the tests did not complete in the expected time");
		$display("Test failed");
		$finish;
	end

	// Expected fail from the shadow registers, using the PMP matching rules
	function automatic logic ref_fail(priv_lvl_e priv, pmp_req_t rq);
		logic [addr_w-1:0] word;
		logic [addr_w-1:0] prev;
		logic [1:0]        mode;
		logic              hit;
		logic              perm;
		int                ones;
		word = rq.paddr[`PMP_PADDR_WIDTH-1:2];
		for (int i = 0; i < entries; i++) begin
			prev = (i == 0) ? '0 : sh_addr[i-1];
			mode = sh_cfg[i][4:3];
			ones = 0;
			while (ones < addr_w && sh_addr[i][ones]) ones++;
			case (mode)
				2'd1: hit = (word >= prev) && (word < sh_addr[i]);
				2'd2: hit = (word == sh_addr[i]);
				2'd3: hit = ({32'd0, word} >> (ones + 1)) == ({32'd0, sh_addr[i]} >> (ones + 1));
				default: hit = 1'b0;
			endcase
			if (hit) begin
				perm = (rq.access == ACCESS_READ) ? sh_cfg[i][0] :
					(rq.access == ACCESS_WRITE) ? sh_cfg[i][1] : sh_cfg[i][2];
				return !perm && ((priv != PRIV_M) || sh_cfg[i][7]);
			end
		end
		return priv != PRIV_M;
	endfunction

	// Shadow state takes writes on the same edge as the DUT registers
	always @(posedge clk) begin
		logic [7:0]        next_cfg [entries];
		logic [addr_w-1:0] next_addr [entries];
		logic              next_lock_tor;
		int                e;
		if (reset_i) begin
			for (int i = 0; i < entries; i++) begin
				sh_cfg[i] = 8'd0;
				sh_addr[i] = '0;
			end
			pend = 1'b0;
		end else begin
			next_cfg = sh_cfg;
			next_addr = sh_addr;
			if (cfg_wr_i.vld) begin
				for (int b = 0; b < 8; b++) begin
					e = int'(cfg_wr_i.idx[0]) * 8 + b;
					if (!sh_cfg[e][7]) next_cfg[e] = cfg_wr_i.data[b*8 +: 8];
				end
			end
			if (addr_wr_i.vld) begin
				e = int'(addr_wr_i.idx);
				next_lock_tor = (e < entries - 1) && sh_cfg[e+1][7] && (sh_cfg[e+1][4:3] == 2'd1);
				if (!sh_cfg[e][7] && !next_lock_tor) next_addr[e] = addr_wr_i.data[addr_w-1:0];
			end
			sh_cfg = next_cfg;
			sh_addr = next_addr;
			pend = check_vld_i;
			pend_req = check_req_i;
		end
	end

	// Compare at the falling edge where all DUT outputs are settled
	always @(negedge clk) begin
		logic        exp_fail;
		logic [63:0] exp_cfg;
		logic [63:0] exp_addr;
		if (!reset_i) begin
			exp_fail = pend ? ref_fail(priv_lvl_i, pend_req) : 1'b0;
			for (int b = 0; b < 8; b++) exp_cfg[b*8 +: 8] = sh_cfg[int'(cfg_wr_i.idx[0]) * 8 + b];
			exp_addr = {32'd0, sh_addr[addr_wr_i.idx]};
			checks++;
			if (check_fail_o !== exp_fail) begin
				$display("mismatch at %0t: check_fail_o got %0b expected %0b", $time,
					check_fail_o, exp_fail);
				errors++;
			end
			if (cfg_rdata_o !== exp_cfg) begin
				$display("mismatch at %0t: cfg_rdata_o got %h expected %h", $time,
					cfg_rdata_o, exp_cfg);
				errors++;
			end
			if (addr_rdata_o !== exp_addr) begin
				$display("mismatch at %0t: addr_rdata_o got %h expected %h", $time,
					addr_rdata_o, exp_addr);
				errors++;
			end
		end
	end

	function automatic pmp_csr_wr_t make_wr(logic v, int idx, logic [63:0] d);
		pmp_csr_wr_t w;
		w.vld = v;
		w.idx = idx[`PMP_IDX_WIDTH-1:0];
		w.data = d;
		return w;
	endfunction

	function automatic pmp_req_t make_req(logic [31:0] word, access_e acc);
		pmp_req_t r;
		r.paddr = {word, 2'($urandom)}; // Any byte within the word
		r.access = acc;
		return r;
	endfunction

	task automatic drive(pmp_csr_wr_t cw, pmp_csr_wr_t aw, logic cv, pmp_req_t rq);
		@(posedge clk);
		priv_lvl_i <= cur_priv;
		cfg_wr_i <= cw;
		addr_wr_i <= aw;
		check_vld_i <= cv;
		check_req_i <= rq;
	endtask

	task automatic idle(int idx);
		drive(make_wr(1'b0, idx, 64'd0), make_wr(1'b0, idx, 64'd0), 1'b0, check_req_i);
	endtask

	task automatic write_cfg(int sel, logic [63:0] data);
		drive(make_wr(1'b1, sel, data), make_wr(1'b0, 0, 64'd0), 1'b0, check_req_i);
	endtask

	task automatic write_addr(int idx, logic [63:0] data);
		drive(make_wr(1'b0, 0, 64'd0), make_wr(1'b1, idx, data), 1'b0, check_req_i);
	endtask

	task automatic check_word(logic [31:0] word, access_e acc);
		drive(make_wr(1'b0, 0, 64'd0), make_wr(1'b0, 0, 64'd0), 1'b1, make_req(word, acc));
	endtask

	task automatic change_priv(priv_lvl_e p);
		idle(0); // A staged check still resolves under the old privilege
		cur_priv = p;
		idle(0);
	endtask

	task automatic sweep_readback();
		for (int i = 0; i < entries; i++) idle(i);
	endtask

	task automatic apply_reset();
		@(posedge clk);
		reset_i <= 1'b1;
		repeat (8) @(posedge clk);
		reset_i <= 1'b0;
	endtask

	task automatic end_test(string name);
		idle(0);
		idle(0);
		$display("%s finished with %0d errors", name, errors - errors_at_start);
		errors_at_start = errors;
	endtask

	initial begin
		seed_val = $urandom(32'hfb26_ce1e);
		errors = 0;
		checks = 0;
		errors_at_start = 0;
		cur_priv = PRIV_M;
		reset_i = 1'b1;
		priv_lvl_i = PRIV_M;
		cfg_wr_i = make_wr(1'b0, 0, 64'd0);
		addr_wr_i = make_wr(1'b0, 0, 64'd0);
		check_vld_i = 1'b0;
		check_req_i = '0;
		spots = '{32'h0, 32'hff, 32'h100, 32'h1ff, 32'h200, 32'h201, 32'h3ff, 32'h400,
			32'h407, 32'h408};
		repeat (8) @(posedge clk);
		reset_i <= 1'b0;

		sweep_readback();
		change_priv(PRIV_U);
		check_word(32'h1234, ACCESS_READ);
		change_priv(PRIV_M);
		check_word(32'h1234, ACCESS_READ);
		end_test("reset state");

		write_cfg(0, {$urandom, $urandom} & 64'h7f7f_7f7f_7f7f_7f7f);
		write_cfg(1, {$urandom, $urandom} & 64'h7f7f_7f7f_7f7f_7f7f);
		for (int i = 0; i < entries; i++) write_addr(i, {$urandom, $urandom});
		sweep_readback();
		end_test("write and readback");

		write_cfg(0, 64'h0000_0000_001c_1309); // TOR R, NA4 RW, NAPOT X
		write_cfg(1, 64'd0);
		write_addr(0, 64'h100);
		write_addr(1, 64'h200);
		write_addr(2, 64'h403);
		for (int p = 0; p < 3; p++) begin
			change_priv((p == 0) ? PRIV_U : (p == 1) ? PRIV_S : PRIV_M);
			for (int n = 0; n < 90; n++) begin
				check_word((n % 3 == 0) ? $urandom % 32'h500 : spots[$urandom % 10],
					access_e'(2'($urandom % 3)));
			end
		end
		end_test("address modes and permissions");

		write_cfg(0, 64'h0000_0000_0000_1f18); // Inner NAPOT without permissions wins
		write_addr(0, 64'h1007);
		write_addr(1, 64'h101f);
		change_priv(PRIV_U);
		for (int n = 0; n < 40; n++) check_word(32'h1000 + $urandom % 32'h48,
			access_e'(2'($urandom % 3)));
		end_test("priority");

		apply_reset();
		change_priv(PRIV_M);
		write_addr(4, 64'h50);
		write_addr(5, 64'h80);
		write_cfg(0, 64'h0000_8900_0000_0000); // Entry 5 locked TOR, read only
		write_addr(4, 64'h60);
		write_addr(5, 64'h90);
		write_cfg(0, 64'h0000_0f00_0000_0000);
		idle(4);
		@(negedge clk);
		if (addr_rdata_o !== 64'h50) begin
			$display("mismatch at %0t: addr_rdata_o got %h expected %h", $time,
				addr_rdata_o, 64'h50);
			errors++;
		end
		idle(5);
		check_word(32'h55, ACCESS_WRITE);
		check_word(32'h55, ACCESS_READ);
		change_priv(PRIV_U);
		check_word(32'h55, ACCESS_WRITE);
		end_test("lock");

		apply_reset();
		for (int n = 0; n < 400; n++) begin
			if (n % 50 == 0) cur_priv = ($urandom % 2 == 0) ? PRIV_U : PRIV_M;
			drive(make_wr($urandom % 3 == 0, $urandom % 2, {$urandom, $urandom} &
				(($urandom % 8 == 0) ? 64'hffff_ffff_ffff_ffff : 64'h7f7f_7f7f_7f7f_7f7f)),
				make_wr($urandom % 3 == 0, $urandom % entries, 64'($urandom % 32'h400)),
				1'b1, make_req($urandom % 32'h400, access_e'(2'($urandom % 3))));
		end
		end_test("back-to-back traffic");

		@(negedge clk);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== pmp_top.sv ====
`timescale 1ns/1ps
`include "pmp_cfg.svh"

module pmp_top (
	input  logic                 clk,
	input  logic                 reset_i,
	input  pmp_pkg::priv_lvl_e   priv_lvl_i,
	input  pmp_pkg::pmp_csr_wr_t cfg_wr_i,
	input  pmp_pkg::pmp_csr_wr_t addr_wr_i,
	output logic [63:0]          cfg_rdata_o,
	output logic [63:0]          addr_rdata_o,
	input  logic                 check_vld_i,
	input  pmp_pkg::pmp_req_t    check_req_i,
	output logic                 check_fail_o
);

	import pmp_pkg::*;

	logic     chk_vld;
	pmp_req_t chk_req;
	logic     unit_fail;

	if (`PMP_INPUT_REGISTER) begin : gen_input_reg
		logic     vld_q;
		pmp_req_t req_q;

		always_ff @(posedge clk) begin
			if (reset_i) begin
				vld_q <= 1'b0;
			end else begin
				vld_q <= check_vld_i;
			end
		end

		// Payload holds its last request while no check is presented
		always_ff @(posedge clk) begin
			if (check_vld_i) begin
				req_q <= check_req_i;
			end
		end

		assign chk_vld = vld_q;
		assign chk_req = req_q;
	end else begin : gen_bypass
		assign chk_vld = check_vld_i;
		assign chk_req = check_req_i;
	end

	pmp_unit u_pmp_unit (
		.clk          (clk),
		.reset_i      (reset_i),
		.priv_lvl_i   (priv_lvl_i),
		.cfg_wr_i     (cfg_wr_i),
		.addr_wr_i    (addr_wr_i),
		.cfg_rdata_o  (cfg_rdata_o),
		.addr_rdata_o (addr_rdata_o),
		.req_i        (chk_req),
		.fail_o       (unit_fail)
	);

	assign check_fail_o = chk_vld && unit_fail; // Quiet when no check is staged

endmodule

// ==== pmp_unit.sv ====
`timescale 1ns/1ps
`include "pmp_cfg.svh"

module pmp_unit (
	input  logic                 clk,
	input  logic                 reset_i,
	input  pmp_pkg::priv_lvl_e   priv_lvl_i,
	input  pmp_pkg::pmp_csr_wr_t cfg_wr_i,
	input  pmp_pkg::pmp_csr_wr_t addr_wr_i,
	output logic [63:0]          cfg_rdata_o,
	output logic [63:0]          addr_rdata_o,
	input  pmp_pkg::pmp_req_t    req_i,
	output logic                 fail_o
);

	import pmp_pkg::*;

	localparam int entries   = `PMP_ENTRY_COUNT;
	localparam int cfg_words = `PMP_CFG_WORDS;
	localparam int addr_w    = `PMP_PADDR_WIDTH - 2;
	localparam int idx_w     = `PMP_IDX_WIDTH;
	localparam int cfg_sel_w = $clog2(cfg_words);

	pmp_cfg_u [entries-1:0]                entry_cfg;
	logic [entries-1:0][7:0]               cfg_bytes;
	logic [entries-1:0][addr_w-1:0]        entry_addr;
	logic [entries-1:0]                    lock_tor;
	logic [entries-1:0]                    match;
	logic [entries-1:0]                    deny;
	logic [cfg_words-1:0][63:0]            cfg_word;
	logic [cfg_sel_w-1:0]                  cfg_sel;

	assign cfg_sel = cfg_wr_i.idx[cfg_sel_w-1:0]; // Low index bits pick the cfg word

	for (genvar i = 0; i < entries; i++) begin : gen_entry
		logic              cfg_wr_en;
		logic              addr_wr_en;
		logic              lock_next_tor;
		logic [addr_w-1:0] prev_addr;

		assign cfg_wr_en  = cfg_wr_i.vld && (cfg_sel == cfg_sel_w'(i / 8));
		assign addr_wr_en = addr_wr_i.vld && (addr_wr_i.idx == idx_w'(i));

		// TOR range of entry 0 starts at address zero
		if (i == 0) begin : gen_first
			assign prev_addr = '0;
		end else begin : gen_prev
			assign prev_addr = entry_addr[i-1];
		end

		if (i == entries - 1) begin : gen_last
			assign lock_next_tor = 1'b0;
		end else begin : gen_next
			assign lock_next_tor = lock_tor[i+1];
		end

		pmp_entry u_pmp_entry (
			.clk             (clk),
			.reset_i         (reset_i),
			.priv_i          (priv_lvl_i),
			.cfg_wr_en_i     (cfg_wr_en),
			.cfg_wr_byte_i   (cfg_wr_i.data[(i % 8) * 8 +: 8]),
			.addr_wr_en_i    (addr_wr_en),
			.addr_wr_data_i  (addr_wr_i.data[addr_w-1:0]),
			.lock_next_tor_i (lock_next_tor),
			.prev_addr_i     (prev_addr),
			.cfg_o           (entry_cfg[i]),
			.addr_o          (entry_addr[i]),
			.lock_tor_o      (lock_tor[i]),
			.req_i           (req_i),
			.match_o         (match[i]),
			.deny_o          (deny[i])
		);

		assign cfg_bytes[i] = entry_cfg[i].raw;
	end

	// Eight cfg bytes per readback word, entry 8w in the low byte
	for (genvar w = 0; w < cfg_words; w++) begin : gen_cfg_word
		assign cfg_word[w] = cfg_bytes[w * 8 +: 8];
	end

	assign cfg_rdata_o  = cfg_word[cfg_sel];
	assign addr_rdata_o = {{(64 - addr_w){1'b0}}, entry_addr[addr_wr_i.idx]};

	pmp_priority_sel u_pmp_priority_sel (
		.match_i (match),
		.deny_i  (deny),
		.priv_i  (priv_lvl_i),
		.fail_o  (fail_o)
	);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module pmp_tb -f pmp.f -o pmp_sim

out=$(./obj_dir/pmp_sim)
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
	exit 0
fi
exit 1
